// File: design/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int STALL_W    = 6;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [STALL_W-1:0]    stall_t;

    // link instructions write here
    localparam reg_addr_t LINK_REG = 5'd31;

    // stall vector bits seen by decode
    localparam int STALL_IF = 1;
    localparam int STALL_ID = 2;

    // instruction fields
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 26;
    localparam int RS_HI     = 25;
    localparam int RS_LO     = 21;
    localparam int RT_HI     = 20;
    localparam int RT_LO     = 16;
    localparam int RD_HI     = 15;
    localparam int RD_LO     = 11;
    localparam int SA_HI     = 10;
    localparam int SA_LO     = 6;
    localparam int FUNC_HI   = 5;
    localparam int FUNC_LO   = 0;
    localparam int IMM_HI    = 15;
    localparam int IMM_LO    = 0;
    localparam int INDEX_HI  = 25;
    localparam int INDEX_LO  = 0;

    // alu one-hot, add in the msb
    typedef logic [11:0] alu_op_t;
    localparam int ALU_ADD  = 11;
    localparam int ALU_SUB  = 10;
    localparam int ALU_SLT  = 9;
    localparam int ALU_SLTU = 8;
    localparam int ALU_AND  = 7;
    localparam int ALU_NOR  = 6;
    localparam int ALU_OR   = 5;
    localparam int ALU_XOR  = 4;
    localparam int ALU_SLL  = 3;
    localparam int ALU_SRL  = 2;
    localparam int ALU_SRA  = 1;
    localparam int ALU_LUI  = 0;

    typedef logic [2:0] src1_sel_t;
    localparam int SRC1_RS = 0;
    localparam int SRC1_PC = 1;
    localparam int SRC1_SA = 2;

    typedef logic [3:0] src2_sel_t;
    localparam int SRC2_RT    = 0;
    localparam int SRC2_SIMM  = 1;
    localparam int SRC2_EIGHT = 2;
    localparam int SRC2_ZIMM  = 3;

    // load kind, lb in the msb
    typedef logic [4:0] mem_op_t;
    localparam int MEM_LB  = 4;
    localparam int MEM_LBU = 3;
    localparam int MEM_LH  = 2;
    localparam int MEM_LHU = 1;
    localparam int MEM_LW  = 0;

    // store kind, top bit always zero
    typedef logic [3:0] ram_wen_t;
    localparam int WEN_SB = 2;
    localparam int WEN_SH = 1;
    localparam int WEN_SW = 0;

    // conditional branches sit in the low eight bits
    typedef logic [11:0] br_kind_t;
    localparam int BR_BEQ    = 0;
    localparam int BR_BNE    = 1;
    localparam int BR_BGEZ   = 2;
    localparam int BR_BGTZ   = 3;
    localparam int BR_BLEZ   = 4;
    localparam int BR_BLTZ   = 5;
    localparam int BR_BGEZAL = 6;
    localparam int BR_BLTZAL = 7;
    localparam int BR_J      = 8;
    localparam int BR_JAL    = 9;
    localparam int BR_JR     = 10;
    localparam int BR_JALR   = 11;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LH      = 6'h21;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_LHU     = 6'h25;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SH      = 6'h29;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // regimm selects by the rt field
    localparam reg_addr_t RT_BLTZ   = 5'h00;
    localparam reg_addr_t RT_BGEZ   = 5'h01;
    localparam reg_addr_t RT_BLTZAL = 5'h10;
    localparam reg_addr_t RT_BGEZAL = 5'h11;

endpackage

`default_nettype wire

// File: design/id_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module id_regfile import id_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [2**REG_ADDR_W];

    // register 0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // write-back bypass, index 0 included
    assign rdata1 = (we && raddr1 == waddr) ? wdata : regs[raddr1];
    assign rdata2 = (we && raddr2 == waddr) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// File: design/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import id_pkg::*; (
    input  word_t     inst,
    output alu_op_t   alu_op,
    output src1_sel_t src1_sel,
    output src2_sel_t src2_sel,
    output logic      ram_en,
    output ram_wen_t  ram_wen,
    output mem_op_t   mem_op,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output logic      rf_from_load,
    output br_kind_t  branch_kind
);

    logic [5:0] opcode;
    logic [5:0] func;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic       special;
    logic       regimm;
    logic is_add, is_addu, is_sub, is_subu, is_slt, is_sltu;
    logic is_and, is_or, is_xor, is_nor;
    logic is_sll, is_srl, is_sra, is_sllv, is_srlv, is_srav;
    logic is_addi, is_addiu, is_slti, is_sltiu;
    logic is_andi, is_ori, is_xori, is_lui;
    logic is_lb, is_lbu, is_lh, is_lhu, is_lw, is_sb, is_sh, is_sw;
    logic arith_r, shift_imm, imm_s, imm_z, load, store, link;

    assign opcode  = inst[OPCODE_HI:OPCODE_LO];
    assign func    = inst[FUNC_HI:FUNC_LO];
    assign rt      = inst[RT_HI:RT_LO];
    assign rd      = inst[RD_HI:RD_LO];
    assign special = (opcode == OP_SPECIAL);
    assign regimm  = (opcode == OP_REGIMM);

    // register format
    assign is_add  = special && func == FN_ADD;
    assign is_addu = special && func == FN_ADDU;
    assign is_sub  = special && func == FN_SUB;
    assign is_subu = special && func == FN_SUBU;
    assign is_slt  = special && func == FN_SLT;
    assign is_sltu = special && func == FN_SLTU;
    assign is_and  = special && func == FN_AND;
    assign is_or   = special && func == FN_OR;
    assign is_xor  = special && func == FN_XOR;
    assign is_nor  = special && func == FN_NOR;
    assign is_sll  = special && func == FN_SLL;
    assign is_srl  = special && func == FN_SRL;
    assign is_sra  = special && func == FN_SRA;
    assign is_sllv = special && func == FN_SLLV;
    assign is_srlv = special && func == FN_SRLV;
    assign is_srav = special && func == FN_SRAV;

    // immediates
    assign is_addi  = (opcode == OP_ADDI);
    assign is_addiu = (opcode == OP_ADDIU);
    assign is_slti  = (opcode == OP_SLTI);
    assign is_sltiu = (opcode == OP_SLTIU);
    assign is_andi  = (opcode == OP_ANDI);
    assign is_ori   = (opcode == OP_ORI);
    assign is_xori  = (opcode == OP_XORI);
    assign is_lui   = (opcode == OP_LUI);

    assign is_lb  = (opcode == OP_LB);
    assign is_lbu = (opcode == OP_LBU);
    assign is_lh  = (opcode == OP_LH);
    assign is_lhu = (opcode == OP_LHU);
    assign is_lw  = (opcode == OP_LW);
    assign is_sb  = (opcode == OP_SB);
    assign is_sh  = (opcode == OP_SH);
    assign is_sw  = (opcode == OP_SW);

    assign branch_kind[BR_BEQ]    = (opcode == OP_BEQ);
    assign branch_kind[BR_BNE]    = (opcode == OP_BNE);
    assign branch_kind[BR_BGEZ]   = regimm && rt == RT_BGEZ;
    assign branch_kind[BR_BGTZ]   = (opcode == OP_BGTZ);
    assign branch_kind[BR_BLEZ]   = (opcode == OP_BLEZ);
    assign branch_kind[BR_BLTZ]   = regimm && rt == RT_BLTZ;
    assign branch_kind[BR_BGEZAL] = regimm && rt == RT_BGEZAL;
    assign branch_kind[BR_BLTZAL] = regimm && rt == RT_BLTZAL;
    assign branch_kind[BR_J]      = (opcode == OP_J);
    assign branch_kind[BR_JAL]    = (opcode == OP_JAL);
    assign branch_kind[BR_JR]     = special && func == FN_JR;
    assign branch_kind[BR_JALR]   = special && func == FN_JALR;

    // groups sharing operand and destination rules
    assign arith_r = is_add | is_addu | is_sub | is_subu | is_slt | is_sltu
                   | is_and | is_or | is_xor | is_nor | is_sllv | is_srlv | is_srav;
    assign shift_imm = is_sll | is_srl | is_sra;
    assign imm_s     = is_addi | is_addiu | is_slti | is_sltiu;
    assign imm_z     = is_andi | is_ori | is_xori;
    assign load      = is_lb | is_lbu | is_lh | is_lhu | is_lw;
    assign store     = is_sb | is_sh | is_sw;
    assign link      = branch_kind[BR_JAL] | branch_kind[BR_JALR]
                     | branch_kind[BR_BGEZAL] | branch_kind[BR_BLTZAL];

    // link computes pc + 8
    assign src1_sel[SRC1_RS] = arith_r | imm_s | imm_z | load | store;
    assign src1_sel[SRC1_PC] = link;
    assign src1_sel[SRC1_SA] = shift_imm;

    assign src2_sel[SRC2_RT]    = arith_r | shift_imm;
    assign src2_sel[SRC2_SIMM]  = imm_s | load | store | is_lui;
    assign src2_sel[SRC2_EIGHT] = link;
    assign src2_sel[SRC2_ZIMM]  = imm_z;

    assign alu_op[ALU_ADD]  = is_add | is_addu | is_addi | is_addiu | load | store | link;
    assign alu_op[ALU_SUB]  = is_sub | is_subu;
    assign alu_op[ALU_SLT]  = is_slt | is_slti;
    assign alu_op[ALU_SLTU] = is_sltu | is_sltiu;
    assign alu_op[ALU_AND]  = is_and | is_andi;
    assign alu_op[ALU_NOR]  = is_nor;
    assign alu_op[ALU_OR]   = is_or | is_ori;
    assign alu_op[ALU_XOR]  = is_xor | is_xori;
    assign alu_op[ALU_SLL]  = is_sll | is_sllv;
    assign alu_op[ALU_SRL]  = is_srl | is_srlv;
    assign alu_op[ALU_SRA]  = is_sra | is_srav;
    assign alu_op[ALU_LUI]  = is_lui;

    assign mem_op  = {is_lb, is_lbu, is_lh, is_lhu, is_lw};
    assign ram_en  = load | store;
    assign ram_wen = {1'b0, is_sb, is_sh, is_sw};

    assign rf_we        = arith_r | shift_imm | imm_s | imm_z | is_lui | load | link;
    assign rf_from_load = load;

    // rd for register format, rt for immediates and loads
    assign rf_waddr = ({REG_ADDR_W{arith_r | shift_imm}} & rd)
                    | ({REG_ADDR_W{imm_s | imm_z | is_lui | load}} & rt)
                    | ({REG_ADDR_W{link}} & LINK_REG);

endmodule

`default_nettype wire

// File: design/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward import id_pkg::*; (
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  word_t     rf_rs,
    input  word_t     rf_rt,
    input  logic      ex_we,
    input  reg_addr_t ex_waddr,
    input  word_t     ex_wdata,
    input  mem_op_t   ex_mem_op,
    input  logic      mem_we,
    input  reg_addr_t mem_waddr,
    input  word_t     mem_wdata,
    output word_t     rs_value,
    output word_t     rt_value,
    output logic      stall_for_load
);

    logic rs_ex_hit;
    logic rt_ex_hit;
    logic rs_mem_hit;
    logic rt_mem_hit;

    assign rs_ex_hit  = ex_we && (ex_waddr == rs);
    assign rt_ex_hit  = ex_we && (ex_waddr == rt);
    assign rs_mem_hit = mem_we && (mem_waddr == rs);
    assign rt_mem_hit = mem_we && (mem_waddr == rt);

    // youngest producer wins
    assign rs_value = rs_ex_hit  ? ex_wdata  :
                      rs_mem_hit ? mem_wdata : rf_rs;
    assign rt_value = rt_ex_hit  ? ex_wdata  :
                      rt_mem_hit ? mem_wdata : rf_rt;

    // load data not ready until mem stage
    assign stall_for_load = (|ex_mem_op) && (rs_ex_hit || rt_ex_hit);

endmodule

`default_nettype wire

// File: design/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit import id_pkg::*; (
    input  word_t    pc,
    input  word_t    inst,
    input  word_t    rs_value,
    input  word_t    rt_value,
    input  br_kind_t branch_kind,
    output logic     br_taken,
    output word_t    br_target
);

    word_t pc_plus4;
    word_t br_offset;
    word_t jump_addr;
    logic  rs_eq_rt;
    logic  rs_neg;
    logic  rs_zero;
    logic  cond_kind;

    assign pc_plus4  = pc + 32'd4;
    assign br_offset = {{(WORD_W-18){inst[IMM_HI]}}, inst[IMM_HI:IMM_LO], 2'b00};
    assign jump_addr = {pc_plus4[WORD_W-1:WORD_W-4], inst[INDEX_HI:INDEX_LO], 2'b00};

    assign rs_eq_rt  = (rs_value == rt_value);
    assign rs_neg    = rs_value[WORD_W-1];
    assign rs_zero   = (rs_value == '0);
    assign cond_kind = |branch_kind[BR_BLTZAL:BR_BEQ];

    assign br_taken = (branch_kind[BR_BEQ] & rs_eq_rt)
                    | (branch_kind[BR_BNE] & ~rs_eq_rt)
                    | ((branch_kind[BR_BGEZ] | branch_kind[BR_BGEZAL]) & ~rs_neg)
                    | (branch_kind[BR_BGTZ] & ~rs_neg & ~rs_zero)
                    | (branch_kind[BR_BLEZ] & (rs_neg | rs_zero))
                    | ((branch_kind[BR_BLTZ] | branch_kind[BR_BLTZAL]) & rs_neg)
                    | (|branch_kind[BR_JALR:BR_J]);

    always_comb begin
        if (cond_kind) begin
            br_target = pc_plus4 + br_offset;
        end else if (branch_kind[BR_J] || branch_kind[BR_JAL]) begin
            br_target = jump_addr;
        end else if (branch_kind[BR_JR] || branch_kind[BR_JALR]) begin
            br_target = rs_value;
        end else begin
            br_target = '0;
        end
    end

endmodule

`default_nettype wire

// File: design/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  stall_t    stall,
    input  word_t     fetch_pc,
    input  word_t     inst,
    input  logic      ex_we,
    input  reg_addr_t ex_waddr,
    input  word_t     ex_wdata,
    input  mem_op_t   ex_mem_op,
    input  logic      mem_we,
    input  reg_addr_t mem_waddr,
    input  word_t     mem_wdata,
    input  logic      wb_we,
    input  reg_addr_t wb_waddr,
    input  word_t     wb_wdata,
    output word_t     id_pc,
    output word_t     id_inst,
    output alu_op_t   alu_op,
    output src1_sel_t src1_sel,
    output src2_sel_t src2_sel,
    output logic      ram_en,
    output ram_wen_t  ram_wen,
    output mem_op_t   mem_op,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output logic      rf_from_load,
    output word_t     rs_value,
    output word_t     rt_value,
    output logic      stall_for_load,
    output logic      br_taken,
    output word_t     br_target
);

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rf_rs;
    word_t     rf_rt;
    br_kind_t  branch_kind;

    // fetch held but decode running inserts a bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            id_pc <= '0;
        end else if (stall[STALL_IF] && !stall[STALL_ID]) begin
            id_pc <= '0;
        end else if (!stall[STALL_IF]) begin
            id_pc <= fetch_pc;
        end
    end

    // instruction memory output already lines up with id_pc
    assign id_inst = inst;
    assign rs_addr = inst[RS_HI:RS_LO];
    assign rt_addr = inst[RT_HI:RT_LO];

    id_regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (rs_addr),
        .raddr2 (rt_addr),
        .we     (wb_we),
        .waddr  (wb_waddr),
        .wdata  (wb_wdata),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt)
    );

    inst_decoder u_decoder (
        .inst         (inst),
        .alu_op       (alu_op),
        .src1_sel     (src1_sel),
        .src2_sel     (src2_sel),
        .ram_en       (ram_en),
        .ram_wen      (ram_wen),
        .mem_op       (mem_op),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_from_load (rf_from_load),
        .branch_kind  (branch_kind)
    );

    operand_forward u_forward (
        .rs             (rs_addr),
        .rt             (rt_addr),
        .rf_rs          (rf_rs),
        .rf_rt          (rf_rt),
        .ex_we          (ex_we),
        .ex_waddr       (ex_waddr),
        .ex_wdata       (ex_wdata),
        .ex_mem_op      (ex_mem_op),
        .mem_we         (mem_we),
        .mem_waddr      (mem_waddr),
        .mem_wdata      (mem_wdata),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .stall_for_load (stall_for_load)
    );

    // resolved on forwarded operands
    branch_unit u_branch (
        .pc          (id_pc),
        .inst        (inst),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .branch_kind (branch_kind),
        .br_taken    (br_taken),
        .br_target   (br_target)
    );

endmodule

`default_nettype wire

// File: tests/id_checks.svh
`ifndef ID_CHECKS_SVH
`define ID_CHECKS_SVH

task automatic fail_now(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1);
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
endtask

task automatic check_alu_op(input string name, input alu_op_t got, input alu_op_t exp);
    if (got !== exp) begin
        fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
endtask

task automatic check_src1(input string name, input src1_sel_t got, input src1_sel_t exp);
    if (got !== exp) begin
        fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
endtask

task automatic check_src2(input string name, input src2_sel_t got, input src2_sel_t exp);
    if (got !== exp) begin
        fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
endtask

task automatic check_mem_op(input string name, input mem_op_t got, input mem_op_t exp);
    if (got !== exp) begin
        fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
endtask

task automatic check_ram_wen(input string name, input ram_wen_t got, input ram_wen_t exp);
    if (got !== exp) begin
        fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
endtask

task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
        fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
endtask

`endif

// File: tests/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb import id_pkg::*; ();

    localparam int NCOL = 24;
    localparam int RST_CYCLES = 16;

    logic      clk;
    logic      rst;
    logic      flush;
    stall_t    stall;
    word_t     fetch_pc;
    word_t     inst;
    logic      ex_we;
    reg_addr_t ex_waddr;
    word_t     ex_wdata;
    mem_op_t   ex_mem_op;
    logic      mem_we;
    reg_addr_t mem_waddr;
    word_t     mem_wdata;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;
    word_t     id_pc;
    word_t     id_inst;
    alu_op_t   alu_op;
    src1_sel_t src1_sel;
    src2_sel_t src2_sel;
    logic      ram_en;
    ram_wen_t  ram_wen;
    mem_op_t   mem_op;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      rf_from_load;
    word_t     rs_value;
    word_t     rt_value;
    logic      stall_for_load;
    logic      br_taken;
    word_t     br_target;

    // reference register file
    word_t shadow [32];
    word_t tab [$];
    int    ncases;
    logic  loaded;

    `include "id_checks.svh"

    id_stage id_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t fwd_expect(input reg_addr_t a);
        if (ex_we && ex_waddr == a) return ex_wdata;
        if (mem_we && mem_waddr == a) return mem_wdata;
        if (wb_we && wb_waddr == a) return wb_wdata;
        return shadow[a];
    endfunction

    // branch condition and target straight from the isa rules
    task automatic branch_expect(input word_t pc, input word_t rsv, input word_t rtv,
                                 output logic taken, output word_t target);
        logic [5:0] op;
        logic [5:0] fn;
        reg_addr_t  rtf;
        word_t      pc4;
        word_t      off;
        op     = inst[OPCODE_HI:OPCODE_LO];
        fn     = inst[FUNC_HI:FUNC_LO];
        rtf    = inst[RT_HI:RT_LO];
        pc4    = pc + 32'd4;
        off    = {{14{inst[15]}}, inst[15:0], 2'b00};
        taken  = 1'b0;
        target = '0;
        if (op == OP_BEQ || op == OP_BNE || op == OP_BGTZ || op == OP_BLEZ ||
            (op == OP_REGIMM && (rtf == RT_BGEZ || rtf == RT_BLTZ ||
                                 rtf == RT_BGEZAL || rtf == RT_BLTZAL))) begin
            target = pc4 + off;
            case (op)
                OP_BEQ:  taken = (rsv == rtv);
                OP_BNE:  taken = (rsv != rtv);
                OP_BGTZ: taken = !rsv[31] && rsv != 0;
                OP_BLEZ: taken = rsv[31] || rsv == 0;
                default: taken = (rtf[0] == 1'b1) ? !rsv[31] : rsv[31];
            endcase
        end else if (op == OP_J || op == OP_JAL) begin
            taken  = 1'b1;
            target = {pc4[31:28], inst[25:0], 2'b00};
        end else if (op == OP_SPECIAL && (fn == FN_JR || fn == FN_JALR)) begin
            taken  = 1'b1;
            target = rsv;
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    cnt;
        string line;
        word_t f [NCOL];
        fd = $fopen("tests/id_cases.txt", "r");
        if (fd == 0) fail_now("could not open the case file tests/id_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                          f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                          f[20], f[21], f[22], f[23]);
            if (cnt != NCOL) fail_now($sformatf("case line %0d has too few fields", ncases));
            for (int c = 0; c < NCOL; c++) tab.push_back(f[c]);
            ncases++;
        end
        $fclose(fd);
    endtask

    task automatic fill_regs();
        shadow[0] = '0;
        for (int i = 1; i < 32; i++) begin
            @(negedge clk);
            wb_we     = 1'b1;
            wb_waddr  = reg_addr_t'(i);
            wb_wdata  = $urandom;
            shadow[i] = wb_wdata;
        end
        @(negedge clk);
        wb_we = 1'b0;
    endtask

    task automatic run_case(input int n);
        int        b;
        reg_addr_t ra;
        reg_addr_t rb;
        logic      exp_taken;
        word_t     exp_target;
        b = n * NCOL;
        @(negedge clk);
        flush     = tab[b][0];
        stall     = tab[b+1][STALL_W-1:0];
        fetch_pc  = tab[b+2];
        inst      = tab[b+3];
        ex_we     = tab[b+4][0];
        ex_waddr  = tab[b+5][4:0];
        ex_wdata  = tab[b+6];
        ex_mem_op = tab[b+7][4:0];
        mem_we    = tab[b+8][0];
        mem_waddr = tab[b+9][4:0];
        mem_wdata = tab[b+10];
        wb_we     = tab[b+11][0];
        wb_waddr  = tab[b+12][4:0];
        wb_wdata  = tab[b+13];
        ra = inst[RS_HI:RS_LO];
        rb = inst[RT_HI:RT_LO];
        // before the edge the write-back value only reaches through the bypass
        #2;
        check_word("rs_value", rs_value, fwd_expect(ra));
        check_word("rt_value", rt_value, fwd_expect(rb));
        check_bit("stall_for_load", stall_for_load,
                  (|ex_mem_op) && ex_we && (ex_waddr == ra || ex_waddr == rb));
        @(posedge clk);
        if (wb_we && wb_waddr != 0) shadow[wb_waddr] = wb_wdata;
        #1;
        check_word("id_pc", id_pc, tab[b+23]);
        check_word("id_inst", id_inst, inst);
        check_alu_op("alu_op", alu_op, tab[b+14][11:0]);
        check_src1("src1_sel", src1_sel, tab[b+15][2:0]);
        check_src2("src2_sel", src2_sel, tab[b+16][3:0]);
        check_bit("ram_en", ram_en, tab[b+17][0]);
        check_ram_wen("ram_wen", ram_wen, tab[b+18][3:0]);
        check_mem_op("mem_op", mem_op, tab[b+19][4:0]);
        check_bit("rf_we", rf_we, tab[b+20][0]);
        check_addr("rf_waddr", rf_waddr, tab[b+21][4:0]);
        check_bit("rf_from_load", rf_from_load, tab[b+22][0]);
        check_word("rs_value", rs_value, fwd_expect(ra));
        check_word("rt_value", rt_value, fwd_expect(rb));
        branch_expect(tab[b+23], fwd_expect(ra), fwd_expect(rb), exp_taken, exp_target);
        check_bit("br_taken", br_taken, exp_taken);
        check_word("br_target", br_target, exp_target);
    endtask

    initial begin
        wait (loaded);
        #((RST_CYCLES + ncases * 2 + 50) * 20);
        $display("timeout: the case sequence did not finish in time");
        $display("test failed");
        $fatal(1);
    end

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        stall     = '0;
        fetch_pc  = '0;
        inst      = '0;
        ex_we     = 1'b0;
        ex_waddr  = '0;
        ex_wdata  = '0;
        ex_mem_op = '0;
        mem_we    = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        wb_we     = 1'b0;
        wb_waddr  = '0;
        wb_wdata  = '0;
        loaded    = 1'b0;
        ncases    = 0;
        void'($urandom(82880));
        load_cases();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_word("id_pc", id_pc, '0);
        fill_regs();
        for (int i = 0; i < ncases; i++) begin
            run_case(i);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/id_cases.txt
# flush stall fetch_pc inst ex_we ex_waddr ex_wdata ex_mem_op mem_we mem_waddr mem_wdata wb_we
# wb_waddr wb_wdata | alu src1 src2 ram_en ram_wen mem_op rf_we rf_waddr rf_from_load id_pc
0 0 100 00221820 0 0 0 0 0 0 0 0 0 0 800 1 1 0 0 0 1 3 0 100
0 0 104 00a62022 0 0 0 0 0 0 0 0 0 0 400 1 1 0 0 0 1 4 0 104
0 0 108 0109382b 0 0 0 0 0 0 0 0 0 0 100 1 1 0 0 0 1 7 0 108
0 0 10c 016c5027 0 0 0 0 0 0 0 0 0 0 040 1 1 0 0 0 1 a 0 10c
0 0 110 000e6940 0 0 0 0 0 0 0 0 0 0 008 4 1 0 0 0 1 d 0 110
0 0 114 02307807 0 0 0 0 0 0 0 0 0 0 002 1 1 0 0 0 1 f 0 114
0 0 118 2272fffc 0 0 0 0 0 0 0 0 0 0 800 1 2 0 0 0 1 12 0 118
0 0 11c 36b41234 0 0 0 0 0 0 0 0 0 0 020 1 8 0 0 0 1 14 0 11c
0 0 120 3c16abcd 0 0 0 0 0 0 0 0 0 0 001 0 2 0 0 0 1 16 0 120
0 0 124 fc000000 0 0 0 0 0 0 0 0 0 0 000 0 0 0 0 0 0 0 0 124
0 0 128 8cc50008 0 0 0 0 0 0 0 0 0 0 800 1 2 1 0 01 1 5 1 128
0 0 12c 91070001 0 0 0 0 0 0 0 0 0 0 800 1 2 1 0 08 1 7 1 12c
0 0 130 8549fffe 0 0 0 0 0 0 0 0 0 0 800 1 2 1 0 04 1 9 1 130
0 0 134 a18b0003 0 0 0 0 0 0 0 0 0 0 800 1 2 1 4 0 0 0 0 134
0 0 138 ac220000 0 0 0 0 0 0 0 0 0 0 800 1 2 1 1 0 0 0 0 138
0 0 13c 00221820 1 2 22222222 0 1 1 11111111 0 0 0 800 1 1 0 0 0 1 3 0 13c
0 0 140 00211820 1 1 aaaa5555 01 1 1 11111111 0 0 0 800 1 1 0 0 0 1 3 0 140
0 0 144 00801820 0 0 0 0 0 0 0 1 4 cafef00d 800 1 1 0 0 0 1 3 0 144
0 0 148 00001820 0 0 0 0 0 0 0 1 0 12345678 800 1 1 0 0 0 1 3 0 148
0 0 14c 00a62022 0 5 77 01 0 0 0 0 0 0 400 1 1 0 0 0 1 4 0 14c
0 0 150 10210004 0 0 0 0 0 0 0 0 0 0 000 0 0 0 0 0 0 0 0 150
0 0 154 1422ffff 0 0 0 0 0 0 0 0 0 0 000 0 0 0 0 0 0 0 0 154
0 0 158 04610010 0 0 0 0 0 0 0 0 0 0 000 0 0 0 0 0 0 0 0 158
0 0 15c 1c800020 0 0 0 0 0 0 0 0 0 0 000 0 0 0 0 0 0 0 0 15c
0 0 160 18000008 0 0 0 0 0 0 0 0 0 0 000 0 0 0 0 0 0 0 0 160
0 0 164 04a00002 1 5 80000000 0 0 0 0 0 0 0 000 0 0 0 0 0 0 0 0 164
0 0 168 04d10003 0 0 0 0 0 0 0 0 0 0 800 2 4 0 0 0 1 1f 0 168
0 0 16c 04f00004 0 0 0 0 0 0 0 0 0 0 800 2 4 0 0 0 1 1f 0 16c
0 0 170 08100040 0 0 0 0 0 0 0 0 0 0 000 0 0 0 0 0 0 0 0 170
0 0 174 0fffffff 0 0 0 0 0 0 0 0 0 0 800 2 4 0 0 0 1 1f 0 174
0 0 178 01000008 0 0 0 0 0 0 0 0 0 0 000 0 0 0 0 0 0 0 0 178
0 0 17c 01200009 0 0 0 0 0 0 0 0 0 0 800 2 4 0 0 0 1 1f 0 17c
0 0 200 00000000 0 0 0 0 0 0 0 0 0 0 008 4 1 0 0 0 1 0 0 200
0 6 204 00000000 0 0 0 0 0 0 0 0 0 0 008 4 1 0 0 0 1 0 0 200
0 2 208 00000000 0 0 0 0 0 0 0 0 0 0 008 4 1 0 0 0 1 0 0 0
1 0 20c 00000000 0 0 0 0 0 0 0 0 0 0 008 4 1 0 0 0 1 0 0 0
0 4 210 00000000 0 0 0 0 0 0 0 0 0 0 008 4 1 0 0 0 1 0 0 210

// File: tb.f
+incdir+tests
design/id_pkg.sv
design/id_regfile.sv
design/inst_decoder.sv
design/operand_forward.sv
design/branch_unit.sv
design/id_stage.sv
tests/id_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the decode-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f tb.f --top-module id_stage_tb -Mdir obj_dir; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vid_stage_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if ! grep -q "test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0
